/* list.f */
pq_pkg.sv
pq_cell.sv
pq_sorted_queue.sv
pq_slave_regs.sv
pq_user_logic.sv
tb_pq.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_pq -f list.f

# The grep on the last line sets the exit status
output=$(./obj_dir/Vtb_pq 2>&1) || true
echo "$output"
echo "$output" | grep -qx "RESULT: PASS"

/* tb_pq.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pq;

  import pq_pkg::*;

  localparam int DEPTH       = 8;
  localparam int CLK_NS      = 10;
  localparam int PLANNED_OPS = 320;  // Bus operations over all tests, rounded up
  localparam int TIMEOUT_NS  = PLANNED_OPS * 4 * CLK_NS + 2000;

  logic                    Bus2IP_Clk = 1'b0;
  logic                    rst_n;
  logic [C_SLV_DWIDTH-1:0] Bus2IP_Data;
  logic [C_NUM_BE-1:0]     Bus2IP_BE;
  logic [C_NUM_REG-1:0]    Bus2IP_RdCE;
  logic [C_NUM_REG-1:0]    Bus2IP_WrCE;
  logic [C_SLV_DWIDTH-1:0] IP2Bus_Data;
  logic                    IP2Bus_RdAck;
  logic                    IP2Bus_WrAck;
  logic                    IP2Bus_Error;

  logic [31:0] rng_state = 32'h0bb1_bcbf;
  logic [31:0] ref_key[$];   // Reference model, ascending keys
  logic [31:0] ref_data[$];
  string       current_test = "init";

  pq_user_logic #(.QUEUE_DEPTH(DEPTH)) UUT (
    .Bus2IP_Clk   (Bus2IP_Clk),
    .rst_n        (rst_n),
    .Bus2IP_Data  (Bus2IP_Data),
    .Bus2IP_BE    (Bus2IP_BE),
    .Bus2IP_RdCE  (Bus2IP_RdCE),
    .Bus2IP_WrCE  (Bus2IP_WrCE),
    .IP2Bus_Data  (IP2Bus_Data),
    .IP2Bus_RdAck (IP2Bus_RdAck),
    .IP2Bus_WrAck (IP2Bus_WrAck),
    .IP2Bus_Error (IP2Bus_Error)
  );

  always #(CLK_NS/2) Bus2IP_Clk = ~Bus2IP_Clk;

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("RESULT: FAIL");
    $display("timeout: simulation did not finish");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("RESULT: FAIL");
      $display("error: %s, %s: expected 0x%08h, actual 0x%08h",
               current_test, name, expected, actual);
      $fatal(1, "first mismatch in %s", current_test);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  // Expected register after a byte-enabled write
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic bus_write(input int index, input logic [31:0] data, input logic [3:0] be);
    Bus2IP_WrCE = 8'h01 << index;
    Bus2IP_Data = data;
    Bus2IP_BE   = be;
    #4;
    check("write ack", 32'h1, 32'(IP2Bus_WrAck));
    @(posedge Bus2IP_Clk);
    #1;
    Bus2IP_WrCE = '0;
    Bus2IP_Data = '0;
    Bus2IP_BE   = '0;
  endtask

  task automatic read_ce_pattern(input logic [7:0] ce, output logic [31:0] value);
    Bus2IP_RdCE = ce;
    #4;
    value = IP2Bus_Data;  // Sampled mid-cycle
    check("read ack", 32'(|ce), 32'(IP2Bus_RdAck));
    check("error flag", 32'h0, 32'(IP2Bus_Error));
    @(posedge Bus2IP_Clk);
    #1;
    Bus2IP_RdCE = '0;
  endtask

  task automatic bus_read(input int index, output logic [31:0] value);
    read_ce_pattern(8'h01 << index, value);
  endtask

  // Strobe one cycle later, result the cycle after
  task automatic settle_command();
    repeat (2) @(posedge Bus2IP_Clk);
    #1;
  endtask

  task automatic insert_reference(input logic [31:0] key, input logic [31:0] data);
    int pos;
    if (ref_key.size() < DEPTH)
    begin
      pos = 0;
      while (pos < ref_key.size() && ref_key[pos] <= key)  // Equal keys stay ahead
        pos++;
      ref_key.insert(pos, key);
      ref_data.insert(pos, data);
    end
  endtask

  task automatic remove_reference();
    if (ref_key.size() > 0)
    begin
      ref_key.delete(0);
      ref_data.delete(0);
    end
  endtask

  function automatic logic [31:0] expected_status();
    logic [31:0] s;
    s       = '0;
    s[0]    = (ref_key.size() == DEPTH);
    s[1]    = (ref_key.size() == 0);
    s[15:8] = 8'(ref_key.size());
    return s;
  endfunction

  task automatic verify_head();
    logic [31:0] value;
    bus_read(REG_HEAD_KEY, value);
    check("head key", ref_key.size() > 0 ? ref_key[0] : 32'h0, value);
    bus_read(REG_HEAD_DATA, value);
    check("head data", ref_data.size() > 0 ? ref_data[0] : 32'h0, value);
    bus_read(REG_STATUS, value);
    check("status", expected_status(), value);
  endtask

  task automatic push_entry(input logic [31:0] key, input logic [31:0] data);
    bus_write(REG_KEY_IN, key, 4'hF);
    bus_write(REG_DATA_IN, data, 4'hF);
    bus_write(REG_CMD, 32'h1, 4'hF);
    settle_command();
    insert_reference(key, data);
    verify_head();
  endtask

  task automatic pop_entry();
    verify_head();
    bus_write(REG_CMD, 32'h2, 4'hF);
    settle_command();
    remove_reference();
    verify_head();
  endtask

  task automatic after_reset_values();
    logic [31:0] value;
    current_test = "after_reset";
    verify_head();
    bus_read(REG_CMD, value);
    check("command readback", 32'h0, value);
  endtask

  task automatic register_access();
    int          regs[4];
    logic [3:0]  be_list[3];
    logic [31:0] shadow;
    logic [31:0] word;
    logic [31:0] value;
    current_test = "register_access";
    regs    = '{REG_SCRATCH0, REG_SCRATCH1, REG_KEY_IN, REG_DATA_IN};
    be_list = '{4'b0101, 4'b1000, 4'b0000};
    for (int r = 0; r < 4; r++)
    begin
      next_random(shadow);
      bus_write(regs[r], shadow, 4'hF);
      for (int b = 0; b < 3; b++)
      begin
        next_random(word);
        bus_write(regs[r], word, be_list[b]);
        shadow = merge_bytes(shadow, word, be_list[b]);
        bus_read(regs[r], value);
        check("byte merge", shadow, value);
      end
    end
    read_ce_pattern(8'h00, value);
    check("read without CE", 32'h0, value);
    read_ce_pattern(8'hC0, value);  // Two CEs at once, both scratch registers
    check("read with two CEs", 32'h0, value);
  endtask

  task automatic sorted_order();
    logic [31:0] key;
    logic [31:0] data;
    current_test = "sorted_order";
    for (int i = 0; i < 6; i++)
    begin
      next_random(key);
      next_random(data);
      push_entry(key, data);
    end
    for (int i = 0; i < 6; i++)
      pop_entry();  // Head must follow the model's ascending order
  endtask

  task automatic full_queue();
    logic [31:0] key;
    logic [31:0] data;
    logic [31:0] value;
    current_test = "full_queue";
    for (int i = 0; i < DEPTH; i++)
    begin
      next_random(key);
      next_random(data);
      push_entry(key | 32'h100, data);  // Keeps every key above the refused one
    end
    bus_read(REG_STATUS, value);
    check("full flag", 32'h1, 32'(value[0]));
    push_entry(32'h0, 32'hdead_0009);
    bus_read(REG_HEAD_KEY, value);
    check("head after refused insert", ref_key[0], value);
    bus_read(REG_STATUS, value);
    check("count after refused insert", 32'd8, 32'(value[15:8]));
    for (int i = 0; i < DEPTH; i++)
      pop_entry();
  endtask

  task automatic empty_and_priority();
    logic [31:0] value;
    current_test = "empty_extract";
    pop_entry();
    current_test = "command_priority";
    bus_write(REG_KEY_IN, 32'h0000_0042, 4'hF);
    bus_write(REG_DATA_IN, 32'h0000_0abc, 4'hF);
    bus_write(REG_CMD, 32'h3, 4'hF);  // Both bits, insert only
    settle_command();
    insert_reference(32'h0000_0042, 32'h0000_0abc);
    verify_head();
    bus_read(REG_CMD, value);
    check("command self-clear", 32'h0, value);
    pop_entry();
  endtask

  task automatic equal_keys();
    logic [31:0] order[4];
    logic [31:0] value;
    current_test = "equal_keys";
    order = '{32'h0b0, 32'h0a1, 32'h0a2, 32'h0a3};
    push_entry(32'h50, 32'h0a1);
    push_entry(32'h50, 32'h0a2);
    push_entry(32'h50, 32'h0a3);
    push_entry(32'h10, 32'h0b0);  // Later but smaller key
    for (int i = 0; i < 4; i++)
    begin
      bus_read(REG_HEAD_DATA, value);
      check("arrival order", order[i], value);
      pop_entry();
    end
  endtask

  initial
  begin
    Bus2IP_Data = '0;
    Bus2IP_BE   = '0;
    Bus2IP_RdCE = '0;
    Bus2IP_WrCE = '0;
    rst_n       = 1'b0;
    repeat (4) @(posedge Bus2IP_Clk);
    #1;
    rst_n = 1'b1;
    after_reset_values();
    register_access();
    sorted_order();
    full_queue();
    empty_and_priority();
    equal_keys();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* pq_user_logic.sv */
`timescale 1ns/1ps
`default_nettype none

module pq_user_logic #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                            Bus2IP_Clk,
  input  logic                            rst_n,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] Bus2IP_Data,
  input  logic [pq_pkg::C_NUM_BE-1:0]     Bus2IP_BE,
  input  logic [pq_pkg::C_NUM_REG-1:0]    Bus2IP_RdCE,
  input  logic [pq_pkg::C_NUM_REG-1:0]    Bus2IP_WrCE,
  output logic [pq_pkg::C_SLV_DWIDTH-1:0] IP2Bus_Data,
  output logic                            IP2Bus_RdAck,
  output logic                            IP2Bus_WrAck,
  output logic                            IP2Bus_Error
);

  import pq_pkg::*;

  logic                    insert;
  logic                    extract;
  logic [C_SLV_DWIDTH-1:0] key_in;
  logic [C_SLV_DWIDTH-1:0] data_in;
  logic [C_SLV_DWIDTH-1:0] head_key;
  logic [C_SLV_DWIDTH-1:0] head_data;
  logic                    full;
  logic                    empty;
  logic [C_COUNT_W-1:0]    count;

  pq_slave_regs u_regs (
    .Bus2IP_Clk   (Bus2IP_Clk),
    .rst_n        (rst_n),
    .Bus2IP_Data  (Bus2IP_Data),
    .Bus2IP_BE    (Bus2IP_BE),
    .Bus2IP_RdCE  (Bus2IP_RdCE),
    .Bus2IP_WrCE  (Bus2IP_WrCE),
    .head_key     (head_key),
    .head_data    (head_data),
    .full         (full),
    .empty        (empty),
    .count        (count),
    .IP2Bus_Data  (IP2Bus_Data),
    .IP2Bus_RdAck (IP2Bus_RdAck),
    .IP2Bus_WrAck (IP2Bus_WrAck),
    .insert       (insert),
    .extract      (extract),
    .key_in       (key_in),
    .data_in      (data_in)
  );

  pq_sorted_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .Bus2IP_Clk (Bus2IP_Clk),
    .rst_n      (rst_n),
    .insert     (insert),
    .extract    (extract),
    .key_in     (key_in),
    .data_in    (data_in),
    .head_key   (head_key),
    .head_data  (head_data),
    .full       (full),
    .empty      (empty),
    .count      (count)
  );

  assign IP2Bus_Error = 1'b0;  // No error responses

endmodule

`default_nettype wire

/* pq_slave_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pq_slave_regs (
  input  logic                            Bus2IP_Clk,
  input  logic                            rst_n,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] Bus2IP_Data,
  input  logic [pq_pkg::C_NUM_BE-1:0]     Bus2IP_BE,
  input  logic [pq_pkg::C_NUM_REG-1:0]    Bus2IP_RdCE,
  input  logic [pq_pkg::C_NUM_REG-1:0]    Bus2IP_WrCE,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] head_key,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] head_data,
  input  logic                            full,
  input  logic                            empty,
  input  logic [pq_pkg::C_COUNT_W-1:0]    count,
  output logic [pq_pkg::C_SLV_DWIDTH-1:0] IP2Bus_Data,
  output logic                            IP2Bus_RdAck,
  output logic                            IP2Bus_WrAck,
  output logic                            insert,
  output logic                            extract,
  output logic [pq_pkg::C_SLV_DWIDTH-1:0] key_in,
  output logic [pq_pkg::C_SLV_DWIDTH-1:0] data_in
);

  import pq_pkg::*;

  logic                    wr_valid;     // Exactly one write CE set
  logic                    rd_valid;     // Exactly one read CE set
  logic                    cmd_wr;
  pq_cmd_u                 cmd_word;
  logic [C_SLV_DWIDTH-1:0] scratch0;
  logic [C_SLV_DWIDTH-1:0] scratch1;
  logic [C_SLV_DWIDTH-1:0] status_word;
  logic [C_SLV_DWIDTH-1:0] rd_data;

  // Replace the enabled bytes of old_word with those of new_word
  function automatic logic [C_SLV_DWIDTH-1:0] byte_merge(
    input logic [C_SLV_DWIDTH-1:0] old_word,
    input logic [C_SLV_DWIDTH-1:0] new_word,
    input logic [C_NUM_BE-1:0]     be
  );
    logic [C_SLV_DWIDTH-1:0] merged;
    merged = old_word;
    for (int b = 0; b < C_NUM_BE; b++)
    begin
      if (be[b])
        merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  assign wr_valid = $onehot(Bus2IP_WrCE);
  assign rd_valid = $onehot(Bus2IP_RdCE);

  // Command register holds nothing, so merge against zero
  assign cmd_word.raw = byte_merge('0, Bus2IP_Data, Bus2IP_BE);
  assign cmd_wr       = wr_valid && Bus2IP_WrCE[REG_CMD];

  always_ff @(posedge Bus2IP_Clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      insert   <= 1'b0;
      extract  <= 1'b0;
      key_in   <= '0;
      data_in  <= '0;
      scratch0 <= '0;
      scratch1 <= '0;
    end
    else
    begin
      // One-cycle strobes, insert beats extract
      insert  <= cmd_wr && cmd_word.fields.insert;
      extract <= cmd_wr && cmd_word.fields.extract && !cmd_word.fields.insert;

      if (wr_valid)
      begin
        if (Bus2IP_WrCE[REG_KEY_IN])
          key_in <= byte_merge(key_in, Bus2IP_Data, Bus2IP_BE);
        if (Bus2IP_WrCE[REG_DATA_IN])
          data_in <= byte_merge(data_in, Bus2IP_Data, Bus2IP_BE);
        if (Bus2IP_WrCE[REG_SCRATCH0])
          scratch0 <= byte_merge(scratch0, Bus2IP_Data, Bus2IP_BE);
        if (Bus2IP_WrCE[REG_SCRATCH1])
          scratch1 <= byte_merge(scratch1, Bus2IP_Data, Bus2IP_BE);
      end
    end
  end

  // Live status from the queue
  always_comb
  begin
    status_word                              = '0;
    status_word[STAT_FULL_BIT]               = full;
    status_word[STAT_EMPTY_BIT]              = empty;
    status_word[STAT_COUNT_LSB +: C_COUNT_W] = count;
  end

  // Read mux, anything but a single CE reads zero
  always_comb
  begin
    rd_data = '0;
    if (rd_valid)
    begin
      if (Bus2IP_RdCE[REG_STATUS])
        rd_data = status_word;
      else if (Bus2IP_RdCE[REG_KEY_IN])
        rd_data = key_in;
      else if (Bus2IP_RdCE[REG_DATA_IN])
        rd_data = data_in;
      else if (Bus2IP_RdCE[REG_HEAD_KEY])
        rd_data = head_key;
      else if (Bus2IP_RdCE[REG_HEAD_DATA])
        rd_data = head_data;
      else if (Bus2IP_RdCE[REG_SCRATCH0])
        rd_data = scratch0;
      else if (Bus2IP_RdCE[REG_SCRATCH1])
        rd_data = scratch1;
      // REG_CMD reads back zero
    end
  end

  assign IP2Bus_Data  = rd_data;
  assign IP2Bus_RdAck = |Bus2IP_RdCE;  // Same-cycle ack
  assign IP2Bus_WrAck = |Bus2IP_WrCE;

endmodule

`default_nettype wire

/* pq_sorted_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module pq_sorted_queue #(
  parameter int QUEUE_DEPTH = 16  // At least 2, at most 255
) (
  input  logic                            Bus2IP_Clk,
  input  logic                            rst_n,
  input  logic                            insert,
  input  logic                            extract,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] key_in,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] data_in,
  output logic [pq_pkg::C_SLV_DWIDTH-1:0] head_key,
  output logic [pq_pkg::C_SLV_DWIDTH-1:0] head_data,
  output logic                            full,
  output logic                            empty,
  output logic [pq_pkg::C_COUNT_W-1:0]    count
);

  import pq_pkg::*;

  logic                                     ins_ok;     // Insert that takes effect
  logic                                     ext_ok;     // Extract that takes effect
  logic [QUEUE_DEPTH-1:0]                   valid_v;
  logic [QUEUE_DEPTH-1:0]                   goes_right_v;
  logic [QUEUE_DEPTH-1:0][C_SLV_DWIDTH-1:0] key_v;
  logic [QUEUE_DEPTH-1:0][C_SLV_DWIDTH-1:0] data_v;

  // Neighbour views of the chain, cell 0 is the head
  logic [QUEUE_DEPTH-1:0]                   left_valid_v;
  logic [QUEUE_DEPTH-1:0]                   left_gr_v;
  logic [QUEUE_DEPTH-1:0][C_SLV_DWIDTH-1:0] left_key_v;
  logic [QUEUE_DEPTH-1:0][C_SLV_DWIDTH-1:0] left_data_v;
  logic [QUEUE_DEPTH-1:0]                   right_valid_v;
  logic [QUEUE_DEPTH-1:0][C_SLV_DWIDTH-1:0] right_key_v;
  logic [QUEUE_DEPTH-1:0][C_SLV_DWIDTH-1:0] right_data_v;

  assign full   = valid_v[QUEUE_DEPTH-1];
  assign empty  = !valid_v[0];
  assign ins_ok = insert && !full;
  assign ext_ok = extract && !empty;

  // Head sees a valid, non-moving entry on its left
  assign left_valid_v = {valid_v[QUEUE_DEPTH-2:0], 1'b1};
  assign left_gr_v    = {goes_right_v[QUEUE_DEPTH-2:0], 1'b0};
  assign left_key_v   = {key_v[QUEUE_DEPTH-2:0], {C_SLV_DWIDTH{1'b0}}};
  assign left_data_v  = {data_v[QUEUE_DEPTH-2:0], {C_SLV_DWIDTH{1'b0}}};

  // Tail pulls in an empty entry on extract
  assign right_valid_v = {1'b0, valid_v[QUEUE_DEPTH-1:1]};
  assign right_key_v   = {{C_SLV_DWIDTH{1'b0}}, key_v[QUEUE_DEPTH-1:1]};
  assign right_data_v  = {{C_SLV_DWIDTH{1'b0}}, data_v[QUEUE_DEPTH-1:1]};

  for (genvar i = 0; i < QUEUE_DEPTH; i++)
  begin : g_cell
    pq_cell u_cell (
      .Bus2IP_Clk      (Bus2IP_Clk),
      .rst_n           (rst_n),
      .insert          (ins_ok),
      .extract         (ext_ok),
      .new_key         (key_in),
      .new_data        (data_in),
      .left_valid      (left_valid_v[i]),
      .left_key        (left_key_v[i]),
      .left_data       (left_data_v[i]),
      .left_goes_right (left_gr_v[i]),
      .right_valid     (right_valid_v[i]),
      .right_key       (right_key_v[i]),
      .right_data      (right_data_v[i]),
      .valid           (valid_v[i]),
      .key             (key_v[i]),
      .data            (data_v[i]),
      .goes_right      (goes_right_v[i])
    );
  end

  // Occupancy follows the accepted operations
  always_ff @(posedge Bus2IP_Clk or negedge rst_n)
  begin
    if (!rst_n)
      count <= '0;
    else if (ins_ok)
      count <= count + 1'b1;
    else if (ext_ok)
      count <= count - 1'b1;
  end

  // An empty head reads zero
  assign head_key  = valid_v[0] ? key_v[0] : '0;
  assign head_data = valid_v[0] ? data_v[0] : '0;

endmodule

`default_nettype wire

/* pq_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module pq_cell (
  input  logic                            Bus2IP_Clk,
  input  logic                            rst_n,
  input  logic                            insert,
  input  logic                            extract,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] new_key,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] new_data,
  input  logic                            left_valid,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] left_key,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] left_data,
  input  logic                            left_goes_right,
  input  logic                            right_valid,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] right_key,
  input  logic [pq_pkg::C_SLV_DWIDTH-1:0] right_data,
  output logic                            valid,
  output logic [pq_pkg::C_SLV_DWIDTH-1:0] key,
  output logic [pq_pkg::C_SLV_DWIDTH-1:0] data,
  output logic                            goes_right
);

  logic load_left;
  logic load_new;
  logic load_right;

  // Strictly greater, so equal keys stay ahead of the new one
  assign goes_right = valid && (key > new_key);

  always_comb
  begin
    // Left neighbour moves in, this also fills the first free cell
    load_left  = insert && left_goes_right;
    // Insertion point, either inside the chain or appended at its end
    load_new   = insert && !left_goes_right && (goes_right || (!valid && left_valid));
    load_right = extract && !insert;
  end

  always_ff @(posedge Bus2IP_Clk or negedge rst_n)
  begin
    if (!rst_n)
      valid <= 1'b0;
    else if (load_left)
      valid <= left_valid;
    else if (load_new)
      valid <= 1'b1;
    else if (load_right)
      valid <= right_valid;  // Last cell empties on extract
  end

  always_ff @(posedge Bus2IP_Clk)
  begin
    if (load_left)
    begin
      key  <= left_key;
      data <= left_data;
    end
    else if (load_new)
    begin
      key  <= new_key;
      data <= new_data;
    end
    else if (load_right)
    begin
      key  <= right_key;
      data <= right_data;
    end
  end

endmodule

`default_nettype wire

/* pq_pkg.sv */
`default_nettype none

package pq_pkg;

  // Bus geometry
  localparam int C_SLV_DWIDTH = 32;  // Bus width, also key and data width
  localparam int C_NUM_REG    = 8;   // One chip enable per register
  localparam int C_NUM_BE     = C_SLV_DWIDTH / 8;

  // Register map, index i is selected by CE bit i
  localparam int REG_CMD       = 0;
  localparam int REG_STATUS    = 1;
  localparam int REG_KEY_IN    = 2;
  localparam int REG_DATA_IN   = 3;
  localparam int REG_HEAD_KEY  = 4;
  localparam int REG_HEAD_DATA = 5;
  localparam int REG_SCRATCH0  = 6;
  localparam int REG_SCRATCH1  = 7;

  // Status word layout
  localparam int C_COUNT_W      = 8;
  localparam int STAT_FULL_BIT  = 0;
  localparam int STAT_EMPTY_BIT = 1;
  localparam int STAT_COUNT_LSB = 8;  // Count sits in bits 15:8

  // Command word, seen as a raw bus word or as decoded fields
  typedef struct packed {
    logic [C_SLV_DWIDTH-3:0] reserved;
    logic                    extract;  // Bit 1
    logic                    insert;   // Bit 0
  } pq_cmd_fields_t;

  typedef union packed {
    logic [C_SLV_DWIDTH-1:0] raw;
    pq_cmd_fields_t          fields;
  } pq_cmd_u;

endpackage

`default_nettype wire
